// ==== tb/stq_patterns.txt ====
# D addr size data cmt_id / C cmt_id / F / W idle_cycles
# E word_addr sel data for each write expected on the bus, in bus order
D 00002000 2 11112222 06
E 00000800 f 11112222
D 00002001 1 00001234 07
D 00002008 2 0badf00d 08
W 2
C 06
C 07
F
D 0000200c 1 0000beef 09
E 00000803 3 0000beef
W 2
C 09
D 00003000 2 a5a5a5a5 01
E 00000c00 f a5a5a5a5
D 00003004 2 5a5a5a5a 02
E 00000c01 f 5a5a5a5a
D 00003012 0 000000ab 03
E 00000c04 4 00ab0000
D 00003016 1 1234beef 04
E 00000c05 c beef0000
D 00003017 0 0000007e 05
E 00000c05 8 7e000000
C 02
C 01
C 04
C 03
W 12
C 05

// ==== filelist.f ====
verilog/stq_pkg.sv
verilog/stq_req_stage.sv
verilog/stq_entry_ring.sv
verilog/stq_drain.sv
verilog/stq_top.sv
tb/stq_drain_sva.sv
tb/stq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module stq_tb -f filelist.f -o stq_sim
./obj_dir/stq_sim 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  exit 1
fi

// ==== tb/stq_tb.sv ====
module stq_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 16;
  localparam int WAIT_LIMIT   = 200;

  logic                         clk;
  logic                         reset_n;
  logic                         st_valid;
  stq_pkg::st_req_t             st_req;
  logic                         commit_valid;
  logic [stq_pkg::CMT_ID_W-1:0] commit_id;
  logic                         flush;
  logic                         wb_ack = 1'b0;
  logic                         st_ready;
  stq_pkg::wb_m2s_t             wb;

  logic [65:0] exp_q [$];  // {word adr, sel, dat}
  logic [7:0]  lfsr      = 8'd81;
  logic [1:0]  wait_left = 2'd0;
  logic        busy      = 1'b0;
  logic        saw_full  = 1'b0;

  stq_top #(.DEPTH(4)) dut_i (
    .i_clk           (clk),
    .i_reset_n       (reset_n),
    .i_st_valid      (st_valid),
    .i_st_req        (st_req),
    .i_commit_valid  (commit_valid),
    .i_commit_cmt_id (commit_id),
    .i_flush         (flush),
    .i_wb_ack        (wb_ack),
    .o_st_ready      (st_ready),
    .o_wb            (wb)
  );

  always #4 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // 8 bit fibonacci with taps x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic check_idle_bus(input string phase);
    assert (!wb.cyc)
      else fail_run($sformatf("Error at %0t %s: o_wb.cyc = %b, expected 0", $time, phase,
                              wb.cyc));
    assert (!wb.stb)
      else fail_run($sformatf("Error at %0t %s: o_wb.stb = %b, expected 0", $time, phase,
                              wb.stb));
    assert (st_ready)
      else fail_run($sformatf("Error at %0t %s: o_st_ready = %b, expected 1", $time, phase,
                              st_ready));
  endtask

  task automatic check_write();
    logic [65:0] want;
    assert (exp_q.size() != 0) else fail_run($sformatf("unexpected bus write to %h", wb.adr));
    want = exp_q.pop_front();
    assert (wb.cyc)
      else fail_run($sformatf("Error at %0t: o_wb.cyc = %b, expected 1", $time, wb.cyc));
    assert (wb.we)
      else fail_run($sformatf("Error at %0t: o_wb.we = %b, expected 1", $time, wb.we));
    assert (wb.adr == want[65:36])
      else fail_run($sformatf("Error at %0t: o_wb.adr = %h, expected %h", $time, wb.adr,
                              want[65:36]));
    assert (wb.sel == want[35:32])
      else fail_run($sformatf("Error at %0t: o_wb.sel = %h, expected %h", $time, wb.sel,
                              want[35:32]));
    assert (wb.dat == want[31:0])
      else fail_run($sformatf("Error at %0t: o_wb.dat = %h, expected %h", $time, wb.dat,
                              want[31:0]));
  endtask

  // ------------------------------
  // wishbone slave model
  // ------------------------------
  always @(negedge clk) begin
    if (wb_ack || !wb.stb) begin
      wb_ack = 1'b0;
      busy   = 1'b0;
    end else begin
      if (!busy) begin
        lfsr         = lfsr_next(lfsr);
        wait_left[0] = lfsr[0];
        lfsr         = lfsr_next(lfsr);
        wait_left[1] = lfsr[0];
        busy         = 1'b1;
      end
      if (wait_left == 2'd0) begin
        check_write();
        wb_ack = 1'b1;
      end else begin
        wait_left = wait_left - 2'd1;
      end
    end
  end

  always @(negedge clk) begin
    if (reset_n && !st_ready) saw_full = 1'b1;  // back-pressure seen
  end

  task automatic dispatch_store(input logic [31:0] addr, input logic [1:0] size,
                                input logic [31:0] data, input logic [5:0] id);
    int n;
    st_req.addr   = addr;
    st_req.size   = stq_pkg::st_size_e'(size);
    st_req.data   = data;
    st_req.cmt_id = id;
    st_valid      = 1'b1;
    n = 0;
    while (!st_ready) begin  // only moves on rising edges
      assert (n < WAIT_LIMIT) else fail_run("timeout waiting for o_st_ready");
      n++;
      @(negedge clk);
    end
    @(negedge clk);
    st_valid = 1'b0;
  endtask

  task automatic commit_store(input logic [5:0] id);
    commit_valid = 1'b1;
    commit_id    = id;
    @(negedge clk);
    commit_valid = 1'b0;
  endtask

  task automatic flush_stores();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
  endtask

  initial begin
    int               fd;
    int               code;
    int               n;
    logic [7:0]       cmd;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      c;
    logic [31:0]      d;
    logic [8*128-1:0] rest;
    logic             done;

    clk          = 1'b0;
    reset_n      = 1'b0;
    st_valid     = 1'b0;
    st_req       = '0;
    commit_valid = 1'b0;
    commit_id    = '0;
    flush        = 1'b0;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_idle_bus("during reset");
    end
    reset_n = 1'b1;
    @(negedge clk);
    check_idle_bus("after reset");

    fd = $fopen("tb/stq_patterns.txt", "r");
    assert (fd != 0) else fail_run("cannot open tb/stq_patterns.txt");
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, " %c", cmd);
      if (code != 1) begin
        done = 1'b1;
      end else begin
        case (cmd)
          "D": begin
            code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
            assert (code == 4) else fail_run("malformed D line in pattern file");
            dispatch_store(a, b[1:0], c, d[5:0]);
          end
          "C": begin
            code = $fscanf(fd, "%h", a);
            assert (code == 1) else fail_run("malformed C line in pattern file");
            commit_store(a[5:0]);
          end
          "E": begin
            code = $fscanf(fd, "%h %h %h", a, b, c);
            assert (code == 3) else fail_run("malformed E line in pattern file");
            exp_q.push_back({a[29:0], b[3:0], c});
          end
          "W": begin
            code = $fscanf(fd, "%d", a);
            assert (code == 1) else fail_run("malformed W line in pattern file");
            repeat (a) @(negedge clk);
          end
          "F": flush_stores();
          "#": code = $fgets(rest, fd);
          default: fail_run($sformatf("unknown command %c in pattern file", cmd));
        endcase
      end
    end
    $fclose(fd);

    // ------------------------------
    // drain and wrap up
    // ------------------------------
    n = 0;
    while (exp_q.size() != 0) begin
      assert (n < WAIT_LIMIT) else fail_run("timeout waiting for the expected bus writes");
      n++;
      @(negedge clk);
    end
    repeat (20) @(negedge clk);  // room for a stray write
    assert (!wb.cyc)
      else fail_run($sformatf("Error at %0t: o_wb.cyc = %b, expected 0", $time, wb.cyc));
    assert (saw_full) else fail_run("o_st_ready never dropped with the queue full");
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== tb/stq_drain_sva.sv ====
module stq_drain_sva (
  input logic             i_clk,
  input logic             i_reset_n,
  input logic             i_wb_ack,
  input logic             o_head_pop,
  input stq_pkg::wb_m2s_t o_wb
);
  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------
  // wishbone classic single writes
  // ------------------------------
  a_stb_needs_cyc: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) o_wb.stb |-> o_wb.cyc
  ) else $error("stb high without cyc");

  // request held until the slave acks
  a_hold_until_ack: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (o_wb.stb && !i_wb_ack) |=>
      (o_wb.stb && $stable(o_wb.adr) && $stable(o_wb.dat) && $stable(o_wb.sel))
  ) else $error("bus request changed before ack");

  a_no_pop_in_cycle: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) !(o_head_pop && o_wb.stb)
  ) else $error("head popped while stb is high");

endmodule

bind stq_drain stq_drain_sva drain_sva_i (
  .i_clk      (i_clk),
  .i_reset_n  (i_reset_n),
  .i_wb_ack   (i_wb_ack),
  .o_head_pop (o_head_pop),
  .o_wb       (o_wb)
);

// ==== verilog/stq_top.sv ====
module stq_top #(
  parameter int DEPTH = 4
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_st_valid,
  input  stq_pkg::st_req_t              i_st_req,
  input  logic                          i_commit_valid,
  input  logic [stq_pkg::CMT_ID_W-1:0]  i_commit_cmt_id,
  input  logic                          i_flush,
  input  logic                          i_wb_ack,
  output logic                          o_st_ready,
  output stq_pkg::wb_m2s_t              o_wb
);

  logic                  stage_valid;
  stq_pkg::stq_entry_t   stage_entry;
  logic                  ring_ready;
  logic                  head_valid;
  stq_pkg::entry_state_e head_state;
  stq_pkg::stq_entry_t   head_entry;
  logic                  head_pop;

  // ------------------------------
  // producer, buffer, consumer
  // ------------------------------
  stq_req_stage req_stage_i (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_st_valid    (i_st_valid),
    .i_st_req      (i_st_req),
    .i_flush       (i_flush),
    .i_ring_ready  (ring_ready),
    .o_st_ready    (o_st_ready),
    .o_stage_valid (stage_valid),
    .o_stage_entry (stage_entry)
  );

  stq_entry_ring #(.DEPTH(DEPTH)) entry_ring_i (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_wr_valid      (stage_valid),
    .i_wr_entry      (stage_entry),
    .i_commit_valid  (i_commit_valid),
    .i_commit_cmt_id (i_commit_cmt_id),
    .i_flush         (i_flush),
    .i_head_pop      (head_pop),
    .o_wr_ready      (ring_ready),
    .o_head_valid    (head_valid),
    .o_head_state    (head_state),
    .o_head_entry    (head_entry)
  );

  stq_drain drain_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_head_valid (head_valid),
    .i_head_state (head_state),
    .i_head_entry (head_entry),
    .i_wb_ack     (i_wb_ack),
    .o_head_pop   (head_pop),
    .o_wb         (o_wb)
  );

endmodule

// ==== verilog/stq_drain.sv ====
module stq_drain (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_head_valid,
  input  stq_pkg::entry_state_e i_head_state,
  input  stq_pkg::stq_entry_t   i_head_entry,
  input  logic                  i_wb_ack,
  output logic                  o_head_pop,
  output stq_pkg::wb_m2s_t      o_wb
);

  typedef enum logic [1:0] {
    DR_IDLE  = 2'd0,
    DR_WRITE = 2'd1,
    DR_POP   = 2'd2
  } drain_state_e;

  drain_state_e                   r_state;
  logic [stq_pkg::ADDR_W-3:0]     r_adr;
  logic [stq_pkg::DATA_W-1:0]     r_dat;
  logic [stq_pkg::SEL_W-1:0]      r_sel;
  logic                           w_do_write;
  logic                           w_do_drop;

  assign w_do_write = i_head_valid && (i_head_state == stq_pkg::ST_COMMITTED) &&
                      !i_head_entry.misaligned;
  assign w_do_drop  = i_head_valid && ((i_head_state == stq_pkg::ST_DEAD) ||
                      ((i_head_state == stq_pkg::ST_COMMITTED) && i_head_entry.misaligned));

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= DR_IDLE;
    end else begin
      case (r_state)
        DR_IDLE: begin
          if (w_do_write) r_state <= DR_WRITE;
          else if (w_do_drop) r_state <= DR_POP;  // no bus cycle
        end
        DR_WRITE: begin
          if (i_wb_ack) r_state <= DR_POP;
        end
        default: r_state <= DR_IDLE;
      endcase
    end
  end

  // bus payload, latched as the cycle starts
  always_ff @(posedge i_clk) begin
    if (r_state == DR_IDLE && w_do_write) begin
      r_adr <= i_head_entry.word_addr;
      r_dat <= i_head_entry.data;
      r_sel <= i_head_entry.sel;
    end
  end

  assign o_head_pop = (r_state == DR_POP);

  always_comb begin
    o_wb.cyc = (r_state == DR_WRITE);
    o_wb.stb = (r_state == DR_WRITE);
    o_wb.we  = (r_state == DR_WRITE);
    o_wb.adr = r_adr;
    o_wb.dat = r_dat;
    o_wb.sel = r_sel;
  end

endmodule

// ==== verilog/stq_entry_ring.sv ====
module stq_entry_ring #(
  parameter int DEPTH = 4
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_wr_valid,
  input  stq_pkg::stq_entry_t           i_wr_entry,
  input  logic                          i_commit_valid,
  input  logic [stq_pkg::CMT_ID_W-1:0]  i_commit_cmt_id,
  input  logic                          i_flush,
  input  logic                          i_head_pop,
  output logic                          o_wr_ready,
  output logic                          o_head_valid,
  output stq_pkg::entry_state_e         o_head_state,
  output stq_pkg::stq_entry_t           o_head_entry
);

  localparam int PTR_W = $clog2(DEPTH);

  stq_pkg::stq_entry_t   r_entries [DEPTH];
  stq_pkg::entry_state_e r_state   [DEPTH];
  logic [PTR_W-1:0]      r_head;
  logic [PTR_W-1:0]      r_tail;
  logic [PTR_W:0]        r_count;
  logic                  w_wr;

  assign o_wr_ready = (r_count != (PTR_W+1)'(DEPTH));
  assign w_wr       = i_wr_valid && o_wr_ready;

  // ------------------------------
  // pointers and occupancy
  // ------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= '0;
    end else begin
      if (w_wr) begin
        r_tail <= r_tail + 1'b1;  // wraps, DEPTH is a power of two
      end
      if (i_head_pop) begin
        r_head <= r_head + 1'b1;
      end
      case ({w_wr, i_head_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  // ------------------------------
  // per-entry state
  // ------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        r_state[i] <= stq_pkg::ST_FREE;
      end
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        if (w_wr && (r_tail == PTR_W'(i))) begin
          r_state[i] <= i_flush ? stq_pkg::ST_DEAD : stq_pkg::ST_WAIT_COMMIT;
        end else if (i_head_pop && (r_head == PTR_W'(i))) begin
          r_state[i] <= stq_pkg::ST_FREE;
        end else if (r_state[i] == stq_pkg::ST_WAIT_COMMIT) begin
          // flush beats a commit on the same edge
          if (i_flush) begin
            r_state[i] <= stq_pkg::ST_DEAD;
          end else if (i_commit_valid && (i_commit_cmt_id == r_entries[i].cmt_id)) begin
            r_state[i] <= stq_pkg::ST_COMMITTED;
          end
        end
      end
    end
  end

  // payload
  always_ff @(posedge i_clk) begin
    if (w_wr) begin
      r_entries[r_tail] <= i_wr_entry;
    end
  end

  assign o_head_valid = (r_count != '0);
  assign o_head_state = r_state[r_head];
  assign o_head_entry = r_entries[r_head];

endmodule

// ==== verilog/stq_req_stage.sv ====
module stq_req_stage (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_st_valid,
  input  stq_pkg::st_req_t    i_st_req,
  input  logic                i_flush,
  input  logic                i_ring_ready,
  output logic                o_st_ready,
  output logic                o_stage_valid,
  output stq_pkg::stq_entry_t o_stage_entry
);

  stq_pkg::stq_entry_t         w_entry;
  stq_pkg::stq_entry_t         r_entry;
  logic                        r_valid;
  logic                        w_accept;
  logic [1:0]                  w_off;
  logic [stq_pkg::DATA_W-1:0]  w_data_masked;

  assign w_off      = i_st_req.addr[1:0];
  assign o_st_ready = !r_valid || i_ring_ready;  // empty, or ring takes ours now
  assign w_accept   = i_st_valid && o_st_ready;

  // lane alignment
  always_comb begin
    w_entry.word_addr  = i_st_req.addr[stq_pkg::ADDR_W-1:2];
    w_entry.cmt_id     = i_st_req.cmt_id;
    case (i_st_req.size)
      stq_pkg::SIZE_BYTE: begin
        w_entry.sel        = 4'b0001 << w_off;
        w_entry.misaligned = 1'b0;
        w_data_masked      = stq_pkg::DATA_W'(i_st_req.data[7:0]);
      end
      stq_pkg::SIZE_HALF: begin
        w_entry.sel        = 4'b0011 << w_off;
        w_entry.misaligned = w_off[0];  // odd address
        w_data_masked      = stq_pkg::DATA_W'(i_st_req.data[15:0]);
      end
      default: begin
        w_entry.sel        = 4'b1111;
        w_entry.misaligned = |w_off;
        w_data_masked      = i_st_req.data;
      end
    endcase
    w_entry.data = w_data_masked << {w_off, 3'b000};
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else if (i_flush) begin
      r_valid <= 1'b0;
    end else if (w_accept) begin
      r_valid <= 1'b1;
    end else if (i_ring_ready) begin
      r_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_accept) r_entry <= w_entry;
  end

  assign o_stage_valid = r_valid;
  assign o_stage_entry = r_entry;

endmodule

// ==== verilog/stq_pkg.sv ====
package stq_pkg;

  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 32;
  localparam int SEL_W    = 4;
  localparam int CMT_ID_W = 6;

  // store size as issued by the pipeline
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } st_size_e;

  typedef enum logic [1:0] {
    ST_FREE        = 2'd0,
    ST_WAIT_COMMIT = 2'd1,
    ST_COMMITTED   = 2'd2,
    ST_DEAD        = 2'd3  // flushed, popped without bus cycle
  } entry_state_e;

  typedef struct packed {
    logic [ADDR_W-1:0]   addr;
    st_size_e            size;
    logic [DATA_W-1:0]   data;  // low bits significant
    logic [CMT_ID_W-1:0] cmt_id;
  } st_req_t;

  typedef struct packed {
    logic [ADDR_W-3:0]   word_addr;
    logic [SEL_W-1:0]    sel;
    logic [DATA_W-1:0]   data;  // already on its byte lanes
    logic [CMT_ID_W-1:0] cmt_id;
    logic                misaligned;
  } stq_entry_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-3:0] adr;
    logic [DATA_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
  } wb_m2s_t;

endpackage
